// File: tokenizer.f
rtl/tokenizer_pkg.sv
rtl/char_stream.sv
rtl/token_writer.sv
rtl/mem_arbiter.sv
rtl/token_parser.sv
rtl/tokenizer_top.sv
sim/tb_mem_model.sv
sim/tb_tokenizer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the tokenizer testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f tokenizer.f \
    --top-module tb_tokenizer -o tb_tokenizer \
    && ./obj_dir/tb_tokenizer 2>&1 | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "Simulation reported a failure"; exit 1; } || exit 0

// File: sim/tb_tokenizer.sv
`timescale 1ns/1ns

module tb_tokenizer;
    import tokenizer_pkg::*;

    // The five tests parse about 150 characters; even at four cycles per access
    // plus parser overhead they need a few thousand cycles at most
    localparam int unsigned max_cycles = 20000;

    // Strings live low in memory, token slots well above them
    localparam mem_addr_t str_base = 16'h1000;
    localparam mem_addr_t out_base = 16'h4000;

    logic       clk;
    logic       resetn;
    logic       start;
    mem_addr_t  str_addr;
    mem_addr_t  out_addr;
    logic       idle;
    logic [7:0] token_count;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;

    int unsigned cycle_count;
    int unsigned error_count;
    int unsigned tests_run;
    int unsigned tests_failed;

    // Tokens the current string should give, in slot order
    mem_word_t expected[$];

    tokenizer_top u_dut (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .str_addr    (str_addr),
        .out_addr    (out_addr),
        .idle        (idle),
        .token_count (token_count),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp)
    );

    tb_mem_model u_mem (
        .clk     (clk),
        .resetn  (resetn),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ========================================================================
    // Checking and reference tokens
    // ========================================================================
    task automatic check_value(input mem_word_t got, input mem_word_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    // Past the end of the text the string reads as its nul terminator
    function automatic logic [7:0] char_at(input string s, input int i);
        if (i < s.len())
            return s[i];
        return char_nul;
    endfunction

    // Walks the string the way the tokenizer is specified to and fills expected
    task automatic split_tokens(input string s);
        int         i;
        logic [7:0] q;
        mem_word_t  tok;
        expected.delete();
        i = 0;
        while (1) begin
            while (char_at(s, i) == char_space)
                i++;
            if (char_at(s, i) == char_nul)
                break;
            tok = '0;
            if (char_at(s, i) == char_dquote || char_at(s, i) == char_squote) begin
                // Quoted token keeps delimiters and loses both quotes
                q = char_at(s, i);
                i++;
                while (char_at(s, i) != q && char_at(s, i) != char_nul) begin
                    tok = {tok[55:0], char_at(s, i)};
                    i++;
                end
                if (char_at(s, i) == q)
                    i++;
            end else begin
                while (char_at(s, i) != char_nul && char_at(s, i) != char_space &&
                       char_at(s, i) != char_comma) begin
                    tok = {tok[55:0], char_at(s, i)};
                    i++;
                end
            end
            expected.push_back(tok);
            // Trailing spaces, then at most one comma, belong to this token
            while (char_at(s, i) == char_space)
                i++;
            if (char_at(s, i) == char_comma)
                i++;
        end
    endtask

    function automatic mem_word_t read_word(input mem_addr_t a);
        mem_word_t w;
        for (int b = 0; b < 8; b++)
            w[b*8 +: 8] = u_mem.mem[a + mem_addr_t'(b)];
        return w;
    endfunction

    // ========================================================================
    // Running one string through the DUT
    // ========================================================================
    task automatic wait_idle();
        @(negedge clk);
        while (!idle)
            @(negedge clk);
    endtask

    task automatic run_string(input mem_addr_t saddr, input string s, input string what);
        int unsigned writes_before;
        split_tokens(s);
        for (int i = 0; i < s.len(); i++)
            u_mem.mem[saddr + mem_addr_t'(i)] = s[i];
        u_mem.mem[saddr + mem_addr_t'(s.len())] = char_nul;
        writes_before = u_mem.write_count;

        @(posedge clk);
        str_addr <= saddr;
        out_addr <= out_base;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_idle();

        check_value(mem_word_t'(token_count), mem_word_t'(expected.size()),
                    {what, ": token_count"});
        check_value(mem_word_t'(u_mem.write_count - writes_before),
                    mem_word_t'(expected.size()), {what, ": slot writes"});
        foreach (expected[k])
            check_value(read_word(out_base + mem_addr_t'(8 * k)), expected[k],
                        $sformatf("%s: token %0d", what, k));
    endtask

    task automatic report_test(input string name, input int unsigned errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("PASSED  %s", name);
        end else begin
            tests_failed++;
            $display("FAILED  %s (%0d mismatches)", name, error_count - errors_before);
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================
    task automatic test_plain_words();
        int unsigned errors_before;
        errors_before = error_count;
        run_string(str_base, "   one two  three four   ", "plain words");
        report_test("plain words", errors_before);
    endtask

    task automatic test_commas();
        int unsigned errors_before;
        errors_before = error_count;
        // The double comma leaves an empty token between blue and black
        run_string(str_base, "red,green , blue ,,black", "commas");
        report_test("commas", errors_before);
    endtask

    task automatic test_quotes();
        int unsigned errors_before;
        errors_before = error_count;
        run_string(str_base, "\"a, b c\" 'x y,z' end", "quotes");
        report_test("quotes", errors_before);
    endtask

    task automatic test_long_word();
        int unsigned errors_before;
        errors_before = error_count;
        run_string(str_base, "abcdefghijkl 12345678 mn", "long word");
        report_test("long word", errors_before);
    endtask

    task automatic test_unaligned_and_empty();
        int unsigned errors_before;
        errors_before = error_count;
        run_string(str_base + 16'd3, " first,second third , fourth fifth,sixth", "unaligned");
        run_string(str_base + 16'd5, "", "empty string");
        // Back to back with the previous run, so the count must restart
        run_string(str_base, "x y", "second run");
        report_test("unaligned and empty", errors_before);
    endtask

    initial begin
        clk          = 1'b0;
        resetn       = 1'b0;
        start        = 1'b0;
        str_addr     = '0;
        out_addr     = '0;
        cycle_count  = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;

        repeat (4) @(posedge clk);
        resetn <= 1'b1;

        test_plain_words();
        test_commas();
        test_quotes();
        test_long_word();
        test_unaligned_and_empty();

        $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: sim/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model (
    input  logic                    clk,
    input  logic                    resetn,
    input  tokenizer_pkg::mem_req_t mem_req,
    output tokenizer_pkg::mem_rsp_t mem_rsp
);
    import tokenizer_pkg::*;

    // Byte-wide storage over the whole address space
    logic [7:0] mem [0:65535];

    // Count of completed writes that the testbench reads to spot missing or extra slots
    int unsigned write_count;

    // Access accepted and counting down its latency
    logic        busy;
    int unsigned delay;
    mem_req_t    held;

    // Latencies are drawn in the clocked process below, which seeds its own generator once
    bit seeded = 1'b0;

    // Every byte starts with a value that depends on its full address
    initial begin
        for (int a = 0; a < 65536; a++)
            mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h96;
    end

    always @(posedge clk) begin
        if (!seeded) begin
            void'($urandom(32'h15c2d5fe));
            seeded <= 1'b1;
        end

        if (!resetn) begin
            busy          <= 1'b0;
            delay         <= 0;
            write_count   <= 0;
            mem_rsp.done  <= 1'b0;
            mem_rsp.rdata <= '0;
        end else if (mem_rsp.done) begin
            // The requester still shows its old request on this edge
            mem_rsp.done <= 1'b0;
        end else if (!busy) begin
            if (mem_req.req) begin
                busy  <= 1'b1;
                held  <= mem_req;
                delay <= $urandom_range(4, 1);
            end
        end else if (delay > 1) begin
            delay <= delay - 1;
        end else begin
            busy         <= 1'b0;
            mem_rsp.done <= 1'b1;
            if (held.wr) begin
                for (int b = 0; b < 8; b++)
                    mem[held.addr + mem_addr_t'(b)] = held.wdata[b*8 +: 8];
                write_count <= write_count + 1;
            end else begin
                // Byte 0 of the word comes from the lowest address
                for (int b = 0; b < 8; b++)
                    mem_rsp.rdata[b*8 +: 8] <= mem[held.addr + mem_addr_t'(b)];
            end
        end
    end

endmodule

// File: rtl/tokenizer_top.sv
`timescale 1ns/1ns

module tokenizer_top (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     start,
    input  tokenizer_pkg::mem_addr_t str_addr,
    input  tokenizer_pkg::mem_addr_t out_addr,
    output logic                     idle,
    output logic [7:0]               token_count,
    output tokenizer_pkg::mem_req_t  mem_req,
    input  tokenizer_pkg::mem_rsp_t  mem_rsp
);
    import tokenizer_pkg::*;

    // Parser to character stream
    stream_cmd_e stream_cmd;
    logic        char_valid;
    logic [7:0]  char_data;

    // Parser to token writer
    logic      token_write;
    mem_word_t token_data;
    logic      writer_idle;

    // Reader and writer sides of the arbiter
    mem_req_t rd_req;
    mem_rsp_t rd_rsp;
    mem_req_t wr_req;
    mem_rsp_t wr_rsp;

    // ========================================================================
    // Parser, stream and writer
    // ========================================================================
    token_parser u_parser (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .idle        (idle),
        .stream_cmd  (stream_cmd),
        .char_valid  (char_valid),
        .char_data   (char_data),
        .token_write (token_write),
        .token_data  (token_data),
        .writer_idle (writer_idle)
    );

    char_stream u_stream (
        .clk        (clk),
        .resetn     (resetn),
        .stream_cmd (stream_cmd),
        .str_addr   (str_addr),
        .char_valid (char_valid),
        .char_data  (char_data),
        .rd_req     (rd_req),
        .rd_rsp     (rd_rsp)
    );

    // Start goes straight to the writer so it picks up the output base
    token_writer u_writer (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .out_addr    (out_addr),
        .token_write (token_write),
        .token_data  (token_data),
        .writer_idle (writer_idle),
        .token_count (token_count),
        .wr_req      (wr_req),
        .wr_rsp      (wr_rsp)
    );

    // Reads and writes share the single external port
    mem_arbiter u_arbiter (
        .clk     (clk),
        .resetn  (resetn),
        .rd_req  (rd_req),
        .rd_rsp  (rd_rsp),
        .wr_req  (wr_req),
        .wr_rsp  (wr_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

// File: rtl/token_parser.sv
`timescale 1ns/1ns

module token_parser (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       start,
    output logic                       idle,
    output tokenizer_pkg::stream_cmd_e stream_cmd,
    input  logic                       char_valid,
    input  logic [7:0]                 char_data,
    output logic                       token_write,
    output tokenizer_pkg::mem_word_t   token_data,
    input  logic                       writer_idle
);
    import tokenizer_pkg::*;

    parse_state_e state;

    // Opening quote of the current token, or nul when unquoted
    logic [7:0] in_quote;

    // Token under construction, filled from the low byte upward
    mem_word_t token;

    // Character classes
    logic is_space;
    logic is_comma;
    logic is_nul;
    logic is_quote;
    logic closes_quote;
    logic ends_token;

    assign is_space     = (char_data == char_space);
    assign is_comma     = (char_data == char_comma);
    assign is_nul       = (char_data == char_nul);
    assign is_quote     = (char_data == char_dquote) || (char_data == char_squote);
    assign closes_quote = (in_quote != char_nul) && (char_data == in_quote);

    // Unquoted tokens stop at a delimiter, quoted ones at the matching quote
    // A nul stops either kind so the run can finish
    assign ends_token = is_nul || ((in_quote == char_nul) ? (is_space || is_comma) : closes_quote);

    assign idle       = (state == ps_idle) && !start;
    assign token_data = token;

    // ========================================================================
    // Stream commands
    // ========================================================================
    always_comb begin
        stream_cmd = stream_none;
        case (state)
            ps_idle:
                if (start)
                    stream_cmd = stream_start;
            ps_new_token:
                // Leading spaces and an opening quote are thrown away
                if (char_valid && (is_space || is_quote))
                    stream_cmd = stream_next;
            ps_parse:
                // The closing quote is eaten, any other terminator is kept
                if (char_valid && (!ends_token || closes_quote))
                    stream_cmd = stream_next;
            ps_skip_spaces:
                if (char_valid && is_space)
                    stream_cmd = stream_next;
            ps_skip_comma:
                if (char_valid && is_comma)
                    stream_cmd = stream_next;
            default: ;
        endcase
    end

    // ========================================================================
    // Parser FSM
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= ps_idle;
            in_quote    <= char_nul;
            token_write <= 1'b0;
        end else begin
            token_write <= 1'b0;
            case (state)
                ps_idle:
                    if (start)
                        state <= ps_new_token;
                ps_new_token:
                    if (char_valid) begin
                        if (is_nul) begin
                            state <= ps_complete;
                        end else if (!is_space) begin
                            in_quote <= is_quote ? char_data : char_nul;
                            state    <= ps_parse;
                        end
                    end
                ps_parse:
                    if (char_valid && ends_token)
                        state <= ps_end_token;
                ps_end_token:
                    // Hold the token here until the writer can take it
                    if (writer_idle) begin
                        token_write <= 1'b1;
                        state       <= ps_skip_spaces;
                    end
                ps_skip_spaces:
                    if (char_valid && !is_space)
                        state <= ps_skip_comma;
                ps_skip_comma:
                    if (char_valid)
                        state <= ps_new_token;
                ps_complete:
                    // Idle only after the last token has reached memory
                    if (writer_idle)
                        state <= ps_idle;
                default:
                    state <= ps_idle;
            endcase
        end
    end

    // Token shift register, older bytes drop off the top of a long token
    always_ff @(posedge clk) begin
        if (state == ps_new_token && char_valid && !is_space && !is_nul)
            token <= '0;
        else if (state == ps_parse && char_valid && !ends_token)
            token <= {token[mem_data_bits-9:0], char_data};
    end

    // A consumed character is shown and then withdrawn by the stream
    a_next_valid: assert property (@(posedge clk) disable iff (!resetn)
        (stream_cmd == stream_next) |-> char_valid ##1 !char_valid);

    // The writer is still free in the cycle the registered strobe arrives
    a_write_idle: assert property (@(posedge clk) disable iff (!resetn)
        token_write |-> writer_idle);

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                    clk,
    input  logic                    resetn,
    input  tokenizer_pkg::mem_req_t rd_req,
    output tokenizer_pkg::mem_rsp_t rd_rsp,
    input  tokenizer_pkg::mem_req_t wr_req,
    output tokenizer_pkg::mem_rsp_t wr_rsp,
    output tokenizer_pkg::mem_req_t mem_req,
    input  tokenizer_pkg::mem_rsp_t mem_rsp
);
    import tokenizer_pkg::*;

    // Port is locked to one requester until its done pulse
    logic busy;

    // Owner while busy, and the requester that was served last
    logic owner_wr;
    logic last_wr;

    // Requester selected in this cycle
    logic grant_wr;

    // ========================================================================
    // Grant selection
    // ========================================================================
    always_comb begin
        if (busy)
            grant_wr = owner_wr;
        else if (rd_req.req && wr_req.req)
            // Both waiting, so the one not served last goes first
            grant_wr = !last_wr;
        else
            grant_wr = wr_req.req;
    end

    // With no request at all the reader is selected and its req is low
    assign mem_req = grant_wr ? wr_req : rd_req;

    // Only the owner sees done, read data goes to both unqualified
    always_comb begin
        rd_rsp.done  = mem_rsp.done && busy && !owner_wr;
        rd_rsp.rdata = mem_rsp.rdata;
        wr_rsp.done  = mem_rsp.done && busy && owner_wr;
        wr_rsp.rdata = mem_rsp.rdata;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            owner_wr <= 1'b0;
            last_wr  <= 1'b1;
        end else if (busy) begin
            if (mem_rsp.done) begin
                busy    <= 1'b0;
                last_wr <= owner_wr;
            end
        end else if (rd_req.req || wr_req.req) begin
            busy     <= 1'b1;
            owner_wr <= grant_wr;
        end
    end

    // Memory only answers an access that was granted earlier
    a_done_owned: assert property (@(posedge clk) disable iff (!resetn)
        mem_rsp.done |-> busy);

endmodule

// File: rtl/token_writer.sv
`timescale 1ns/1ns

module token_writer (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      start,
    input  tokenizer_pkg::mem_addr_t  out_addr,
    input  logic                      token_write,
    input  tokenizer_pkg::mem_word_t  token_data,
    output logic                      writer_idle,
    output logic [7:0]                token_count,
    output tokenizer_pkg::mem_req_t   wr_req,
    input  tokenizer_pkg::mem_rsp_t   wr_rsp
);
    import tokenizer_pkg::*;

    // High from the latched token until memory reports done
    logic busy;

    // Next output slot and the token waiting to go there
    mem_addr_t slot_addr;
    mem_word_t pending;

    assign writer_idle = !busy;

    assign wr_req.req   = busy;
    assign wr_req.wr    = 1'b1;
    assign wr_req.addr  = slot_addr;
    assign wr_req.wdata = pending;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy        <= 1'b0;
            token_count <= '0;
        end else begin
            // Each run counts its own tokens
            if (start)
                token_count <= '0;

            if (token_write) begin
                busy <= 1'b1;
            end else if (wr_rsp.done) begin
                busy        <= 1'b0;
                token_count <= token_count + 1'b1;
            end
        end
    end

    // Slots are one word apart, starting at the base given with start
    always_ff @(posedge clk) begin
        if (start)
            slot_addr <= out_addr;
        else if (wr_rsp.done)
            slot_addr <= slot_addr + mem_addr_t'(token_bytes);

        if (token_write)
            pending <= token_data;
    end

endmodule

// File: rtl/char_stream.sv
`timescale 1ns/1ns

module char_stream (
    input  logic                       clk,
    input  logic                       resetn,
    input  tokenizer_pkg::stream_cmd_e stream_cmd,
    input  tokenizer_pkg::mem_addr_t   str_addr,
    output logic                       char_valid,
    output logic [7:0]                 char_data,
    output tokenizer_pkg::mem_req_t    rd_req,
    input  tokenizer_pkg::mem_rsp_t    rd_rsp
);
    import tokenizer_pkg::*;

    // Word currently being handed out byte by byte
    mem_word_t word;

    // Position of the current character inside word
    logic [byte_index_bits-1:0] byte_index;

    // Aligned address of the word being fetched or last fetched
    mem_addr_t fetch_addr;

    // Control flags of the stream
    logic fetching;
    logic valid_q;
    logic stepping;

    assign char_valid = valid_q;
    assign char_data  = word[byte_index*8 +: 8];

    // The read request is a plain level that stays up until done
    assign rd_req.req   = fetching;
    assign rd_req.wr    = 1'b0;
    assign rd_req.addr  = fetch_addr;
    assign rd_req.wdata = '0;

    // ========================================================================
    // Control flags
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetching <= 1'b0;
            valid_q  <= 1'b0;
            stepping <= 1'b0;
        end else begin
            // A step inside the word shows the next byte one cycle later
            stepping <= 1'b0;
            if (stepping)
                valid_q <= 1'b1;

            case (stream_cmd)
                stream_start: begin
                    fetching <= 1'b1;
                    valid_q  <= 1'b0;
                end
                stream_next: begin
                    valid_q <= 1'b0;
                    // Running off the top byte needs the following word
                    if (&byte_index)
                        fetching <= 1'b1;
                    else
                        stepping <= 1'b1;
                end
                default: ;
            endcase

            if (rd_rsp.done) begin
                fetching <= 1'b0;
                valid_q  <= 1'b1;
            end
        end
    end

    // ========================================================================
    // Word buffer, byte index and fetch address
    // ========================================================================
    always_ff @(posedge clk) begin
        if (stream_cmd == stream_start) begin
            fetch_addr <= {str_addr[mem_addr_bits-1:byte_index_bits], {byte_index_bits{1'b0}}};
            byte_index <= str_addr[byte_index_bits-1:0];
        end else if (stream_cmd == stream_next) begin
            // The index wraps to byte 0 of the next word on its own
            byte_index <= byte_index + 1'b1;
            if (&byte_index)
                fetch_addr <= fetch_addr + mem_addr_t'(token_bytes);
        end

        if (rd_rsp.done)
            word <= rd_rsp.rdata;
    end

    // A pending read stays a read at a fixed address until memory answers
    a_rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        (rd_req.req && !rd_rsp.done) |=> (rd_req.req && !rd_req.wr && $stable(rd_req.addr)));

endmodule

// File: rtl/tokenizer_pkg.sv
package tokenizer_pkg;

    // ========================================================================
    // Widths of the memory port and of a token
    // ========================================================================

    // Byte address width of the shared memory port
    localparam int unsigned mem_addr_bits = 16;

    // One memory word holds exactly one token
    localparam int unsigned mem_data_bits = 64;

    // Bytes per memory word, which is also the output slot stride
    localparam int unsigned token_bytes = mem_data_bits / 8;

    // Width of a byte position inside one word
    localparam int unsigned byte_index_bits = $clog2(token_bytes);

    // ========================================================================
    // ASCII codes the parser looks for
    // ========================================================================
    localparam logic [7:0] char_nul    = 8'h00;
    localparam logic [7:0] char_space  = 8'h20;
    localparam logic [7:0] char_dquote = 8'h22;
    localparam logic [7:0] char_squote = 8'h27;
    localparam logic [7:0] char_comma  = 8'h2c;

    typedef logic [mem_addr_bits-1:0] mem_addr_t;
    typedef logic [mem_data_bits-1:0] mem_word_t;

    // Request side of the memory port
    // Req is a level held until done, wr selects a write
    typedef struct packed {
        logic      req;
        logic      wr;
        mem_addr_t addr;
        mem_word_t wdata;
    } mem_req_t;

    // Response side of the memory port, done is a single-cycle pulse
    typedef struct packed {
        logic      done;
        mem_word_t rdata;
    } mem_rsp_t;

    // Strobes from the parser to the character stream
    typedef enum logic [1:0] {
        stream_none,
        stream_start,
        stream_next
    } stream_cmd_e;

    // Parser FSM states
    typedef enum logic [2:0] {
        ps_idle,
        ps_new_token,
        ps_parse,
        ps_end_token,
        ps_skip_spaces,
        ps_skip_comma,
        ps_complete
    } parse_state_e;

endpackage
